// ==== Makefile ====
# Verilator build and run for the synth core testbench
# override any variable on the command line, e.g. make run OBJ_DIR=build

VERILATOR ?= verilator
TOP       ?= tb_synth_top
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0
PASS_MSG  ?= Simulation PASSED

SRCS := $(shell cat $(FILELIST))
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only if the pass line shows up in the simulator output
run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== compile.f ====
rtl/synth_pkg.sv
rtl/adc_serial_reader.sv
rtl/wave_osc.sv
rtl/amp_stage.sv
rtl/i2s_transmitter.sv
rtl/synth_top.sv
tb/tb_clock_gen.sv
tb/adc_model.sv
tb/tb_synth_top.sv

// ==== rtl/adc_serial_reader.sv ====
/*
 * AD7606 serial read, two data lines, four channels per line
 * busy and frstdata are ignored, the wait half of the frame covers conversion
 * channels hold until the next frame_valid pulse
 */
`timescale 1ns/1ps

module adc_serial_reader (
	input  logic clk,
	input  logic rst,
	input  logic db7,   // serial data, channels 0..3
	input  logic db8,   // serial data, channels 4..7
	output logic conv,
	output logic cs,
	output logic rdclk,
	output synth_pkg::sample_t channels [synth_pkg::ADC_CHANNELS],
	output logic frame_valid
);

	logic [synth_pkg::ADC_DIV_W-1:0] div_cnt; // clk per step
	logic                            step_en;
	synth_pkg::adc_step_t            step;
	synth_pkg::adc_step_t            step_nxt;
	logic                            sample_now;
	logic [1:0]                      grp;     // channel within a line
	synth_pkg::sample_t raw_lo [synth_pkg::ADC_CHANNELS/2]; // db7 shift regs
	synth_pkg::sample_t raw_hi [synth_pkg::ADC_CHANNELS/2]; // db8 shift regs

	assign step_en    = (div_cnt == synth_pkg::ADC_DIV_LAST);
	assign step_nxt   = step + 8'd1;
	assign sample_now = step_en & ~step[7] & ~step[0]; // even read steps
	assign grp        = step[6:5];                     // 32 steps per channel

	assign conv = (step != synth_pkg::CONV_STEP); // single low step in the wait
	assign cs   = step[7];

	// ----------------------------------------------------------
	// step sequencer and rdclk
	// ----------------------------------------------------------
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			div_cnt <= '0;
			step    <= '0;
			rdclk   <= 1'b0;
		end else begin
			div_cnt <= div_cnt + 1'b1;
			if (step_en) begin
				step <= step_nxt;
				if (step_nxt[0])
					rdclk <= 1'b1;      // adc shifts out next bit
				else if (!step_nxt[7])
					rdclk <= 1'b0;      // stays high through the wait
			end
		end
	end

	// msb first, sampled at the end of each low rdclk step
	always_ff @(posedge clk) begin
		if (sample_now) begin
			raw_lo[grp] <= {raw_lo[grp][14:0], db7};
			raw_hi[grp] <= {raw_hi[grp][14:0], db8};
		end
	end

	// ----------------------------------------------------------
	// publish all channels as the step enters 128
	// ----------------------------------------------------------
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			frame_valid <= 1'b0;
			for (int i = 0; i < synth_pkg::ADC_CHANNELS; i++)
				channels[i] <= '0;
		end else begin
			frame_valid <= step_en && (step == synth_pkg::ADC_READ_LAST);
			if (step_en && (step == synth_pkg::ADC_READ_LAST)) begin
				for (int g = 0; g < synth_pkg::ADC_CHANNELS/2; g++) begin
					channels[g] <= raw_lo[g] + synth_pkg::SIGN_OFFSET;
					channels[g + synth_pkg::ADC_CHANNELS/2] <= raw_hi[g] + synth_pkg::SIGN_OFFSET;
				end
			end
		end
	end

endmodule

// ==== rtl/amp_stage.sv ====
/*
 * gain stage, unsigned 16x16 multiply keeping the upper half
 * gain is zero unless the gain channel is above mid scale
 * two register stages, both hold under back-pressure
 */
`timescale 1ns/1ps

module amp_stage (
	input  logic               clk,
	input  logic               rst,
	input  synth_pkg::sample_t in_sample,
	input  synth_pkg::sample_t gain_raw,
	input  logic               in_valid,
	input  logic               out_ready,
	output logic               in_ready,
	output synth_pkg::sample_t out_sample,
	output logic               out_valid
);

	synth_pkg::sample_t gain;
	synth_pkg::sample_t s1_wave;
	synth_pkg::sample_t s1_gain;
	logic               s1_valid;
	logic               s2_load;
	logic [31:0]        prod;

	// upper half of the cv only, doubled to full scale
	assign gain = gain_raw[15] ? {gain_raw[14:0], 1'b0} : '0;

	assign s2_load  = !out_valid || out_ready;   // output empty or draining
	assign in_ready = !s1_valid || s2_load;      // stage 1 empty or moving on
	assign prod     = 32'(s1_wave) * 32'(s1_gain);

	// ----------------------------------------------------------
	// pipeline control
	// ----------------------------------------------------------
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			s1_valid  <= 1'b0;
			out_valid <= 1'b0;
		end else begin
			if (in_ready)
				s1_valid <= in_valid;
			if (s2_load)
				out_valid <= s1_valid;
		end
	end

	// payload
	always_ff @(posedge clk) begin
		if (in_ready && in_valid) begin
			s1_wave <= in_sample;
			s1_gain <= gain;
		end
		if (s2_load && s1_valid)
			out_sample <= prod[31:16];
	end

endmodule

// ==== rtl/i2s_transmitter.sv ====
/*
 * 16 bit I2S sender for a PCM5102, same word on left and right
 * takes one word per 256 clk frame, repeats the last word if none is offered
 */
`timescale 1ns/1ps

module i2s_transmitter (
	input  logic               clk,
	input  logic               rst,
	input  synth_pkg::sample_t sample,
	input  logic               valid,
	output logic               ready,
	output logic               din,
	output logic               bck,
	output logic               lrck
);

	logic [synth_pkg::DAC_DIV_W-1:0] div_cnt;
	logic                            step_en;
	synth_pkg::i2s_step_t            step;
	synth_pkg::i2s_step_t            step_nxt;
	synth_pkg::sample_t              word;     // word on the wire
	synth_pkg::sample_t              word_nxt;

	assign step_en  = (div_cnt == synth_pkg::DAC_DIV_LAST);
	assign step_nxt = step + 6'd1;

	// frame boundary, end of step 63
	assign ready    = step_en && (step == synth_pkg::I2S_LAST_STEP);
	assign word_nxt = (ready && valid) ? sample : word;

	// ----------------------------------------------------------
	// step counter and pins, pins follow the step register
	// ----------------------------------------------------------
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			div_cnt <= '0;
			step    <= '0;
			word    <= '0;
			lrck    <= 1'b0;
			bck     <= 1'b0;
			din     <= 1'b0;
		end else begin
			div_cnt <= div_cnt + 1'b1;
			if (step_en) begin
				step <= step_nxt;
				word <= word_nxt;
				lrck <= step_nxt[5];                        // low = left
				bck  <= step_nxt[0];
				din  <= word_nxt[4'd15 - step_nxt[4:1]];    // msb first
			end
		end
	end

endmodule

// ==== rtl/synth_pkg.sv ====
/*
 * shared widths, types and timing for the single voice synth core
 * one clk domain, every derived rate is a clock enable
 * ADC_STEP_CLKS and DAC_STEP_CLKS must stay powers of two (dividers wrap)
 */
package synth_pkg;

	// ----------------------------------------------------------
	// data types
	// ----------------------------------------------------------
	typedef logic [15:0] sample_t;   // audio or cv, offset binary
	typedef logic [28:0] phase_t;    // oscillator phase accumulator
	typedef logic [7:0]  adc_step_t; // 0..127 read with cs low, 128..255 wait
	typedef logic [5:0]  i2s_step_t; // 32 steps left, 32 steps right

	typedef enum logic [2:0] {
		WAVE_OFF         = 3'd0,
		WAVE_NOISE       = 3'd1,
		WAVE_SAW         = 3'd2,
		WAVE_SQUARE      = 3'd3,
		WAVE_MULTISQ     = 3'd4,
		WAVE_SINE_UNUSED = 3'd5, // no table, outputs zero
		WAVE_OFF2        = 3'd6,
		WAVE_THRU        = 3'd7  // channel 0 straight through
	} wave_mode_t;

	// ----------------------------------------------------------
	// ADC timing, 2 clk per step -> 512 clk per frame
	// ----------------------------------------------------------
	localparam int ADC_CHANNELS  = 8;
	localparam int ADC_STEP_CLKS = 2;
	localparam int ADC_DIV_W     = $clog2(ADC_STEP_CLKS);
	localparam logic [ADC_DIV_W-1:0] ADC_DIV_LAST = ADC_DIV_W'(ADC_STEP_CLKS - 1);
	localparam adc_step_t ADC_READ_LAST = 8'd127; // last step with cs low
	localparam adc_step_t CONV_STEP     = 8'd129; // conv pulses low here

	// DAC timing, 4 clk per step -> 256 clk per frame
	localparam int DAC_STEP_CLKS = 4;
	localparam int DAC_DIV_W     = $clog2(DAC_STEP_CLKS);
	localparam logic [DAC_DIV_W-1:0] DAC_DIV_LAST = DAC_DIV_W'(DAC_STEP_CLKS - 1);
	localparam i2s_step_t I2S_LAST_STEP = 6'd63;

	// ----------------------------------------------------------
	// channel map and constants
	// ----------------------------------------------------------
	localparam sample_t SIGN_OFFSET = 16'h8000; // two's complement -> offset binary
	localparam int PITCH_CH = 0;
	localparam int MODE_CH  = 1; // top three bits pick the wave
	localparam int GAIN_CH  = 4;

	localparam logic [31:0] LFSR_SEED = 32'hABAB_ABAB;   // noise start state
	localparam logic [30:0] LFSR_TAPS = 31'h0000_0062;   // feedback taps

endpackage

// ==== rtl/synth_top.sv ====
/*
 * single voice synth, AD7606 cv in, PCM5102 audio out
 * ch0 pitch, ch1 wave select (top 3 bits), ch4 gain
 */
`timescale 1ns/1ps

module synth_top (
	input  logic clk,
	input  logic rst,
	input  logic db7,
	input  logic db8,
	output logic conv,
	output logic cs,
	output logic rdclk,
	output logic din,
	output logic bck,
	output logic lrck
);

	synth_pkg::sample_t    channels [synth_pkg::ADC_CHANNELS];
	synth_pkg::wave_mode_t mode;
	synth_pkg::sample_t    osc_sample;
	logic                  osc_valid;
	logic                  osc_ready;
	synth_pkg::sample_t    amp_sample;
	logic                  amp_valid;
	logic                  amp_ready;

	assign mode = synth_pkg::wave_mode_t'(channels[synth_pkg::MODE_CH][15:13]);

	// ----------------------------------------------------------
	// cv in
	// ----------------------------------------------------------
	adc_serial_reader adc_serial_reader_i (
		.clk(clk), .rst(rst), .db7(db7), .db8(db8),
		.conv(conv), .cs(cs), .rdclk(rdclk),
		.channels(channels),
		.frame_valid() // channels hold between frames
	);

	// oscillator -> gain -> dac
	wave_osc wave_osc_i (
		.clk(clk), .rst(rst),
		.pitch(channels[synth_pkg::PITCH_CH]),
		.thru(channels[synth_pkg::PITCH_CH]),
		.mode(mode),
		.ready(osc_ready), .sample(osc_sample), .valid(osc_valid)
	);

	amp_stage amp_stage_i (
		.clk(clk), .rst(rst),
		.in_sample(osc_sample), .gain_raw(channels[synth_pkg::GAIN_CH]),
		.in_valid(osc_valid), .out_ready(amp_ready), .in_ready(osc_ready),
		.out_sample(amp_sample), .out_valid(amp_valid)
	);

	i2s_transmitter i2s_transmitter_i (
		.clk(clk), .rst(rst),
		.sample(amp_sample), .valid(amp_valid), .ready(amp_ready),
		.din(din), .bck(bck), .lrck(lrck)
	);

endmodule

// ==== rtl/wave_osc.sv ====
/*
 * phase accumulator oscillator with noise, saw and square shapes
 * increment is roughly pitch^4 / 2^48, two clk of multiply latency
 * valid stays high after reset, sample holds while ready is low
 */
`timescale 1ns/1ps

module wave_osc (
	input  logic                  clk,
	input  logic                  rst,
	input  synth_pkg::sample_t    pitch,
	input  synth_pkg::sample_t    thru,   // pass through source
	input  synth_pkg::wave_mode_t mode,
	input  logic                  ready,
	output synth_pkg::sample_t    sample,
	output logic                  valid
);

	logic [31:0]        pitch_sq;
	logic [31:0]        inc_sq;
	synth_pkg::sample_t pitch_sq_q; // upper half of pitch^2
	synth_pkg::sample_t inc_q;      // phase increment
	synth_pkg::phase_t  phase;
	logic [31:0]        lfsr;
	synth_pkg::sample_t wave;

	// ----------------------------------------------------------
	// pitch curve, squared twice
	// ----------------------------------------------------------
	assign pitch_sq = 32'(pitch) * 32'(pitch);
	assign inc_sq   = 32'(pitch_sq_q) * 32'(pitch_sq_q);

	always_ff @(posedge clk) begin
		pitch_sq_q <= pitch_sq[31:16];
		inc_q      <= inc_sq[31:16];
	end

	// phase and noise run every clk
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			phase <= '0;
			lfsr  <= synth_pkg::LFSR_SEED;
		end else begin
			phase <= phase + synth_pkg::phase_t'(inc_q);
			if (lfsr[31])
				lfsr[31:1] <= lfsr[30:0] ^ synth_pkg::LFSR_TAPS;
			else
				lfsr[31:1] <= lfsr[30:0];
			lfsr[0] <= lfsr[31]; // rotate msb back in
		end
	end

	// ----------------------------------------------------------
	// wave select
	// ----------------------------------------------------------
	always_comb begin
		case (mode)
			synth_pkg::WAVE_NOISE:   wave = lfsr[31:16];
			synth_pkg::WAVE_SAW:     wave = phase[28:13];
			synth_pkg::WAVE_SQUARE:  wave = {phase[28], 15'd0};
			synth_pkg::WAVE_MULTISQ: wave = {phase[28:27], 14'd0};
			synth_pkg::WAVE_THRU:    wave = thru;
			synth_pkg::WAVE_OFF,
			synth_pkg::WAVE_SINE_UNUSED,
			synth_pkg::WAVE_OFF2:    wave = '0;
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			valid <= 1'b0;
		else
			valid <= 1'b1; // free running source
	end

	always_ff @(posedge clk) begin
		if (ready || !valid)
			sample <= wave; // hold under back-pressure
	end

endmodule

// ==== tb/adc_model.sv ====
/*
 * behavioral AD7606 serial output, db7 carries ch0..3, db8 ch4..7
 * msb is on the line after cs falls, next bit after each rdclk rise
 * conversion, busy and frstdata are not modelled
 */
`timescale 1ns/1ps

module adc_model (
	input  logic        rst,
	input  logic        cs,
	input  logic        rdclk,
	input  logic [15:0] values [8], // two's complement codes
	output logic        db7,
	output logic        db8
);

	logic [6:0]  rise_cnt;  // free running count of rdclk rises
	logic [6:0]  start_cnt; // rise count when cs last fell
	logic [6:0]  bit_idx;   // bits already shifted out this frame
	logic [63:0] stream_lo;
	logic [63:0] stream_hi;

	assign stream_lo = {values[0], values[1], values[2], values[3]};
	assign stream_hi = {values[4], values[5], values[6], values[7]};

	always @(posedge rdclk or posedge rst) begin
		if (rst)
			rise_cnt <= '0;
		else
			rise_cnt <= rise_cnt + 7'd1;
	end

	// new read cycle, restart at bit 63 of each line
	always @(negedge cs or posedge rst) begin
		if (rst)
			start_cnt <= '0;
		else
			start_cnt <= rise_cnt;
	end

	assign bit_idx = rise_cnt - start_cnt;
	assign db7     = bit_idx[6] ? 1'b0 : stream_lo[~bit_idx[5:0]]; // 63 - idx
	assign db8     = bit_idx[6] ? 1'b0 : stream_hi[~bit_idx[5:0]];

endmodule

// ==== tb/tb_clock_gen.sv ====
/*
 * testbench clock and reset, 4 ns period
 * rst high from time zero, released on a rising edge after 16 cycles
 */
`timescale 1ns/1ps

module tb_clock_gen (
	output logic clk,
	output logic rst
);

	localparam int HALF_PERIOD_NS = 2;
	localparam int RESET_CYCLES   = 16;

	initial clk = 1'b0;
	always #(HALF_PERIOD_NS) clk = ~clk;

	initial begin
		rst <= 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0; // released on the edge
	end

endmodule

// ==== tb/tb_synth_top.sv ====
/*
 * directed tests of synth_top through its ADC and I2S pins only
 * controls change in the ADC wait half, words are read three ADC frames later
 * run stops at the first wrong value, a cycle limit catches a stuck bus
 */
`timescale 1ns/1ps

module tb_synth_top;

	// ------------------------------------------------------------
	// run length
	// ------------------------------------------------------------
	localparam int ADC_FRAME_CLKS = 256 * synth_pkg::ADC_STEP_CLKS;
	localparam int SETTLE_FRAMES  = 3;  // ADC frames until a new cv is heard
	localparam int THRU_RUNS      = 4;
	localparam int SILENCE_DAC    = 4;  // DAC frames per silent case
	localparam int SQUARE_DAC     = 32;
	localparam int NOISE_DAC      = 16;
	localparam int TEST_FRAMES    = 2 + THRU_RUNS * (SETTLE_FRAMES + 3)
		+ 3 * (SETTLE_FRAMES + 2 + SILENCE_DAC / 2)
		+ (SETTLE_FRAMES + 2 + SQUARE_DAC / 2)
		+ (SETTLE_FRAMES + 2 + NOISE_DAC / 2);
	localparam int TIMEOUT_CLKS   = TEST_FRAMES * ADC_FRAME_CLKS * 5 / 4; // 25% slack

	localparam logic [15:0] FULL_CV = 16'h7FFF; // top of the two's complement range

	logic        clk;
	logic        rst;
	logic        db7;
	logic        db8;
	logic        conv;
	logic        cs;
	logic        rdclk;
	logic        din;
	logic        bck;
	logic        lrck;
	logic [15:0] adc_vals [synth_pkg::ADC_CHANNELS]; // two's complement
	int          cycles = 0;
	integer      seed;

	tb_clock_gen clock_gen_i (.clk(clk), .rst(rst));

	adc_model adc_model_i (
		.rst(rst), .cs(cs), .rdclk(rdclk), .values(adc_vals),
		.db7(db7), .db8(db8)
	);

	synth_top synth_top_i (
		.clk(clk), .rst(rst), .db7(db7), .db8(db8),
		.conv(conv), .cs(cs), .rdclk(rdclk),
		.din(din), .bck(bck), .lrck(lrck)
	);

	// ------------------------------------------------------------
	// error reporting and compares
	// ------------------------------------------------------------
	task automatic stop_on_error(input string line);
		$display("%s", line);
		$display("Simulation FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_sample(input string what, input synth_pkg::sample_t got,
			input synth_pkg::sample_t exp);
		if (got !== exp)
			stop_on_error($sformatf("Mismatch at %0t: %s got %h expected %h",
				$time, what, got, exp));
	endtask

	task automatic check_count(input string what, input int got, input int exp);
		if (got != exp)
			stop_on_error($sformatf("Mismatch at %0t: %s got %0d expected %0d",
				$time, what, got, exp));
	endtask

	task automatic check_level(input string what, input logic got, input logic exp);
		if (got !== exp)
			stop_on_error($sformatf("Mismatch at %0t: %s got %b expected %b",
				$time, what, got, exp));
	endtask

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles == TIMEOUT_CLKS)
			stop_on_error($sformatf("timeout, tests still running after %0d clk cycles",
				cycles));
	end

	// ------------------------------------------------------------
	// expected values from the cv rules
	// ------------------------------------------------------------
	function automatic synth_pkg::sample_t to_offset(input logic [15:0] raw);
		return raw + synth_pkg::SIGN_OFFSET;
	endfunction

	function automatic logic [15:0] to_raw(input synth_pkg::sample_t off);
		return off - synth_pkg::SIGN_OFFSET;
	endfunction

	// adc code whose top three offset bits select the wave
	function automatic logic [15:0] mode_code(input synth_pkg::wave_mode_t m);
		return to_raw({m, 13'd0});
	endfunction

	// upper half of wave * (2 * gain cv mod 2^16), silent below mid scale
	function automatic synth_pkg::sample_t scaled(input synth_pkg::sample_t wave,
			input synth_pkg::sample_t gain_cv);
		synth_pkg::sample_t gain;
		logic [31:0]        prod;
		gain = gain_cv + gain_cv;
		if (!gain_cv[15])
			gain = '0;
		prod = 32'(wave) * 32'(gain);
		return prod[31:16];
	endfunction

	// ------------------------------------------------------------
	// stimulus and capture
	// ------------------------------------------------------------
	task automatic apply_controls(input logic [15:0] pitch_raw, input logic [15:0] mode_raw,
			input logic [15:0] gain_raw);
		@(posedge cs); // wait half, nothing is read now
		@(posedge clk);
		adc_vals[synth_pkg::PITCH_CH] <= pitch_raw;
		adc_vals[synth_pkg::MODE_CH]  <= mode_raw;
		adc_vals[synth_pkg::GAIN_CH]  <= gain_raw;
		repeat (SETTLE_FRAMES) @(posedge cs);
	endtask

	// din only moves on bck falling edges, so rising edges see a settled bit
	task automatic capture_frame(output synth_pkg::sample_t left,
			output synth_pkg::sample_t right);
		left  = '0;
		right = '0;
		@(negedge lrck); // frame starts with the left word
		repeat (16) begin
			@(posedge bck);
			check_level("lrck in left half", lrck, 1'b0);
			left = {left[14:0], din};
		end
		repeat (16) begin
			@(posedge bck);
			check_level("lrck in right half", lrck, 1'b1);
			right = {right[14:0], din};
		end
	endtask

	// ------------------------------------------------------------
	// tests
	// ------------------------------------------------------------
	task automatic test_reset_state();
		@(negedge clk);
		while (rst) begin
			check_level("conv in reset", conv, 1'b1);
			check_level("cs in reset", cs, 1'b0);
			check_level("rdclk in reset", rdclk, 1'b0);
			check_level("lrck in reset", lrck, 1'b0);
			check_level("bck in reset", bck, 1'b0);
			check_level("din in reset", din, 1'b0);
			@(negedge clk);
		end
		// rdclk and bck already toggle here
		repeat (16) begin
			check_level("conv after reset", conv, 1'b1);
			check_level("cs after reset", cs, 1'b0);
			check_level("lrck after reset", lrck, 1'b0);
			check_level("din after reset", din, 1'b0);
			@(negedge clk);
		end
	endtask

	task automatic test_bus_schedule();
		int   rises;
		int   conv_lows;
		logic rdclk_q;
		logic conv_q;
		rises     = 0;
		conv_lows = 0;
		rdclk_q   = 1'b0;
		conv_q    = 1'b1;
		@(negedge cs); // frame start
		repeat (ADC_FRAME_CLKS) begin
			@(negedge clk);
			if (rdclk && !rdclk_q && !cs)
				rises++;
			if (!conv && conv_q)
				conv_lows++;
			if (!conv)
				check_level("cs while conv low", cs, 1'b1);
			rdclk_q = rdclk;
			conv_q  = conv;
		end
		check_count("rdclk rises with cs low", rises, synth_pkg::ADC_CHANNELS / 2 * 16);
		check_count("conv low pulses per frame", conv_lows, 1);
	endtask

	task automatic test_thru();
		logic [31:0]        r;
		logic [15:0]        pitch_raw;
		logic [15:0]        gain_raw;
		synth_pkg::sample_t left;
		synth_pkg::sample_t right;
		synth_pkg::sample_t exp;
		repeat (THRU_RUNS) begin
			r         = $random(seed);
			pitch_raw = r[15:0];
			gain_raw  = to_raw({1'b1, r[30:16]}); // gain cv above mid scale
			apply_controls(pitch_raw, mode_code(synth_pkg::WAVE_THRU), gain_raw);
			exp = scaled(to_offset(pitch_raw), to_offset(gain_raw));
			repeat (2) begin
				capture_frame(left, right);
				check_sample("thru left word", left, exp);
				check_sample("thru right word", right, exp);
			end
		end
	endtask

	task automatic expect_silence(input string what, input logic [15:0] pitch_raw,
			input logic [15:0] mode_raw, input logic [15:0] gain_raw);
		synth_pkg::sample_t left;
		synth_pkg::sample_t right;
		apply_controls(pitch_raw, mode_raw, gain_raw);
		repeat (SILENCE_DAC) begin
			capture_frame(left, right);
			check_sample({what, " left word"}, left, 16'h0000);
			check_sample({what, " right word"}, right, 16'h0000);
		end
	endtask

	task automatic test_square();
		synth_pkg::sample_t left;
		synth_pkg::sample_t right;
		synth_pkg::sample_t high_word;
		int                 highs;
		int                 lows;
		highs = 0;
		lows  = 0;
		// half period near 16 DAC frames at this pitch
		apply_controls(FULL_CV, mode_code(synth_pkg::WAVE_SQUARE), FULL_CV);
		high_word = scaled(16'h8000, to_offset(FULL_CV));
		repeat (SQUARE_DAC) begin
			capture_frame(left, right);
			check_sample("square right vs left", right, left);
			if (left == high_word)
				highs++;
			else begin
				check_sample("square low level", left, 16'h0000);
				lows++;
			end
		end
		check_count("square high level seen", (highs > 0) ? 1 : 0, 1);
		check_count("square low level seen", (lows > 0) ? 1 : 0, 1);
	endtask

	task automatic test_noise();
		synth_pkg::sample_t first;
		synth_pkg::sample_t left;
		synth_pkg::sample_t right;
		int                 changes;
		changes = 0;
		apply_controls(16'h0000, mode_code(synth_pkg::WAVE_NOISE), FULL_CV);
		capture_frame(first, right);
		check_sample("noise right vs left", right, first);
		repeat (NOISE_DAC - 1) begin
			capture_frame(left, right);
			check_sample("noise right vs left", right, left);
			if (left != first)
				changes++;
		end
		check_count("noise word changes", (changes > 0) ? 1 : 0, 1);
	endtask

	initial begin
		seed = 29958;
		// distinct codes so a channel slip shows up in the mode and gain cv
		for (int i = 0; i < synth_pkg::ADC_CHANNELS; i++)
			adc_vals[i] <= 16'h1111 * 16'(i);
		test_reset_state();
		test_bus_schedule();
		test_thru();
		expect_silence("mode off", 16'h1234, mode_code(synth_pkg::WAVE_OFF), FULL_CV);
		expect_silence("mode sine", 16'h1234, mode_code(synth_pkg::WAVE_SINE_UNUSED),
			FULL_CV);
		expect_silence("low gain", 16'h4000, mode_code(synth_pkg::WAVE_THRU), 16'hF000);
		test_square();
		test_noise();
		$display("Simulation PASSED");
		$finish;
	end

endmodule
